//--- include/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath width in bits.
`define MIPS_XLEN 32

// architectural register count with register 0 reading as zero.
`define MIPS_NREGS 32

// data memory depth in words.
`define MIPS_DMEM_WORDS 64

// first fetch address after reset.
`define MIPS_RESET_PC 32'h0000_0000

`endif

//--- design/mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } mips_opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a
    } mips_funct_e;

    typedef struct packed {
        logic         reg_dst;     // rd when set, rt otherwise.
        logic         reg_write;
        logic         alu_src_imm; // second operand is the immediate.
        logic         ext_sign;
        logic         mem_read;
        logic         mem_write;
        logic         mem_to_reg;
        logic         beq;
        logic         bne;
        logic         jump;
        mips_opcode_e alu_op;
    } mips_ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [4:0]            rd;
        logic [`MIPS_XLEN-1:0] data;
    } mips_wb_t;

endpackage

//--- design/mips_control.sv
`timescale 1ns/1ns

module mips_control
    import mips_pkg::*;
(
    input  mips_opcode_e i_instr_code,
    input  logic         i_live,
    output mips_ctrl_t   o_ctrl,
    output logic         o_unknown_command
);

    always_comb
    begin
        o_ctrl            = '0;
        o_ctrl.alu_op     = i_instr_code; // the alu decodes the opcode itself.
        o_unknown_command = 1'b0;

        case (i_instr_code)
            OP_RTYPE:
            begin
                o_ctrl.reg_dst   = 1'b1;
                o_ctrl.reg_write = i_live;
            end
            OP_ADDI, OP_ADDIU:
            begin
                o_ctrl.reg_write   = i_live;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.ext_sign    = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                o_ctrl.reg_write   = i_live;
                o_ctrl.alu_src_imm = 1'b1; // zero extended.
            end
            OP_LW:
            begin
                o_ctrl.reg_write   = i_live;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.ext_sign    = 1'b1;
                o_ctrl.mem_read    = i_live;
                o_ctrl.mem_to_reg  = i_live;
            end
            OP_SW:
            begin
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.ext_sign    = 1'b1;
                o_ctrl.mem_write   = i_live;
            end
            OP_J:
            begin
                o_ctrl.jump = i_live;
            end
            OP_BEQ:
            begin
                o_ctrl.ext_sign = 1'b1;
                o_ctrl.beq      = i_live;
            end
            OP_BNE:
            begin
                o_ctrl.ext_sign = 1'b1;
                o_ctrl.bne      = i_live;
            end
            default:
            begin
                o_unknown_command = 1'b1; // cop0 and anything else lands here.
            end
        endcase
    end

endmodule

//--- design/mips_regfile.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module mips_regfile #(
    parameter int AW = $clog2(`MIPS_NREGS)
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [AW-1:0]         i_rs_addr,
    input  logic [AW-1:0]         i_rt_addr,
    input  logic                  i_wr_en,
    input  logic [AW-1:0]         i_wr_addr,
    input  logic [`MIPS_XLEN-1:0] i_wr_data,
    output logic [`MIPS_XLEN-1:0] o_rs_data,
    output logic [`MIPS_XLEN-1:0] o_rt_data
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < `MIPS_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wr_en && (i_wr_addr != '0))
        begin
            regs[i_wr_addr] <= i_wr_data; // writes to r0 are dropped.
        end
    end

    assign o_rs_data = regs[i_rs_addr];
    assign o_rt_data = regs[i_rt_addr];

    // r0 storage stays zero across any write history.
    a_r0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rs_addr == '0) |-> (o_rs_data == '0));

endmodule

//--- design/mips_alu.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module mips_alu
    import mips_pkg::*;
(
    input  logic [`MIPS_XLEN-1:0] i_op_a,
    input  logic [`MIPS_XLEN-1:0] i_op_b,
    input  mips_ctrl_t            i_ctrl,
    input  mips_funct_e           i_funct,
    input  logic [4:0]            i_shamt,
    output logic [`MIPS_XLEN-1:0] o_result,
    output logic                  o_zero
);

    logic slt;

    assign slt = ($signed(i_op_a) < $signed(i_op_b));

    always_comb
    begin
        case (i_ctrl.alu_op)
            OP_RTYPE:
            begin
                case (i_funct)
                    FN_SLL:          o_result = i_op_b << i_shamt;
                    FN_SRL:          o_result = i_op_b >> i_shamt; // logical.
                    FN_ADD, FN_ADDU: o_result = i_op_a + i_op_b;
                    FN_SUB, FN_SUBU: o_result = i_op_a - i_op_b;
                    FN_AND:          o_result = i_op_a & i_op_b;
                    FN_OR:           o_result = i_op_a | i_op_b;
                    FN_XOR:          o_result = i_op_a ^ i_op_b;
                    FN_NOR:          o_result = ~(i_op_a | i_op_b);
                    FN_SLT:          o_result = {{(`MIPS_XLEN-1){1'b0}}, slt};
                    default:         o_result = '0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_LW, OP_SW:
            begin
                o_result = i_op_a + i_op_b; // no overflow trap.
            end
            OP_BEQ, OP_BNE:
            begin
                o_result = i_op_a - i_op_b;
            end
            OP_ANDI: o_result = i_op_a & i_op_b;
            OP_ORI:  o_result = i_op_a | i_op_b;
            OP_XORI: o_result = i_op_a ^ i_op_b;
            OP_LUI:  o_result = i_op_b << 16;
            default: o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

//--- design/mips_data_mem.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module mips_data_mem #(
    parameter int AW = $clog2(`MIPS_DMEM_WORDS)
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_wr_en,
    input  logic [`MIPS_XLEN-1:0] i_addr,
    input  logic [`MIPS_XLEN-1:0] i_wr_data,
    output logic [`MIPS_XLEN-1:0] o_rd_data
);

    logic [`MIPS_XLEN-1:0] mem [`MIPS_DMEM_WORDS];
    logic [AW-1:0]         word_idx;

    assign word_idx = i_addr[AW+1:2]; // byte offset and upper bits ignored.

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < `MIPS_DMEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (i_wr_en)
        begin
            mem[word_idx] <= i_wr_data;
        end
    end

    assign o_rd_data = mem[word_idx];

endmodule

//--- design/mips_core.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module mips_core
    import mips_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [`MIPS_XLEN-1:0] i_instr,
    input  logic                  i_instr_valid,
    output logic [`MIPS_XLEN-1:0] o_pc,
    output mips_wb_t              o_wb,
    output logic                  o_unknown_command
);

    mips_opcode_e          opcode;
    mips_funct_e           funct;
    logic [4:0]            rs, rt, rd, shamt;
    logic [15:0]           imm;
    logic [25:0]           target;
    logic                  live;
    logic                  squash;
    mips_ctrl_t            ctrl;
    logic                  unknown;
    logic [`MIPS_XLEN-1:0] rs_data, rt_data;
    logic [`MIPS_XLEN-1:0] imm_ext, op_b;
    logic [`MIPS_XLEN-1:0] alu_result, mem_rd_data, wb_data;
    logic                  alu_zero;
    logic [4:0]            wr_addr;
    logic                  taken;
    logic [`MIPS_XLEN-1:0] pc_plus4, pc_next;

    assign opcode = mips_opcode_e'(i_instr[31:26]);
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign shamt  = i_instr[10:6];
    assign funct  = mips_funct_e'(i_instr[5:0]);
    assign imm    = i_instr[15:0];
    assign target = i_instr[25:0];

    assign live = i_instr_valid && !squash; // the slot after a redirect is dropped.

    mips_control u_control (
        .i_instr_code      (opcode),
        .i_live            (live),
        .o_ctrl            (ctrl),
        .o_unknown_command (unknown)
    );

    assign wr_addr = ctrl.reg_dst ? rd : rt;

    mips_regfile u_regfile (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs_addr (rs),
        .i_rt_addr (rt),
        .i_wr_en   (ctrl.reg_write),
        .i_wr_addr (wr_addr),
        .i_wr_data (wb_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    assign imm_ext = ctrl.ext_sign ? {{16{imm[15]}}, imm} : {16'b0, imm};
    assign op_b    = ctrl.alu_src_imm ? imm_ext : rt_data;

    mips_alu u_alu (
        .i_op_a   (rs_data),
        .i_op_b   (op_b),
        .i_ctrl   (ctrl),
        .i_funct  (funct),
        .i_shamt  (shamt),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    mips_data_mem u_data_mem (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (ctrl.mem_write),
        .i_addr    (alu_result),
        .i_wr_data (rt_data),
        .o_rd_data (mem_rd_data)
    );

    assign wb_data = ctrl.mem_to_reg ? mem_rd_data : alu_result;

    assign taken    = (ctrl.beq && alu_zero) || (ctrl.bne && !alu_zero);
    assign pc_plus4 = o_pc + `MIPS_XLEN'(4);

    always_comb
    begin
        if (ctrl.jump)
            pc_next = {pc_plus4[31:28], target, 2'b00};
        else if (taken)
            pc_next = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
        else
            pc_next = pc_plus4;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_pc              <= `MIPS_RESET_PC;
            squash            <= 1'b0;
            o_wb              <= '0;
            o_unknown_command <= 1'b0;
        end
        else
        begin
            if (i_instr_valid)
            begin
                o_pc   <= pc_next;
                squash <= taken || ctrl.jump; // both are zero while squashing.
            end
            o_wb.valid        <= ctrl.reg_write;
            o_wb.rd           <= wr_addr;
            o_wb.data         <= wb_data;
            o_unknown_command <= unknown && live;
        end
    end

    // an unknown opcode must never retire a register write.
    a_wb_vs_unknown: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_wb.valid && o_unknown_command));

endmodule

//--- test/tb_mips_core.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module tb_mips_core
    import mips_pkg::*;
#(
    parameter int SEED = 32'h1991_b788
);

    localparam int MAX_CYCLES = 2000; // far above the ~70 cycles the directed tests take.

    logic                  i_clk;
    logic                  i_rst_n;
    logic [`MIPS_XLEN-1:0] i_instr;
    logic                  i_instr_valid;
    logic [`MIPS_XLEN-1:0] o_pc;
    mips_wb_t              o_wb;
    logic                  o_unknown_command;

    logic [`MIPS_XLEN-1:0] m_regs [`MIPS_NREGS];
    logic [`MIPS_XLEN-1:0] m_mem [`MIPS_DMEM_WORDS];
    logic [`MIPS_XLEN-1:0] m_pc;
    logic                  m_squash;
    int                    seed;
    int                    errors;
    int                    cycles = 0;

    mips_core dut (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_instr           (i_instr),
        .i_instr_valid     (i_instr_valid),
        .o_pc              (o_pc),
        .o_wb              (o_wb),
        .o_unknown_command (o_unknown_command)
    );

    initial i_clk = 1'b0;
    always #4 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] r_format(input logic [5:0] fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_format(input logic [25:0] target);
        return {OP_J, target};
    endfunction

    function automatic mips_wb_t make_wb(input logic [4:0] rd, input logic [31:0] data);
        return '{valid: 1'b1, rd: rd, data: data};
    endfunction

    function automatic logic [31:0] rtype_result(input logic [5:0] fn, input logic [31:0] a,
                                                 input logic [31:0] b, input logic [4:0] sh);
        case (fn)
            FN_SLL:          return b << sh;
            FN_SRL:          return b >> sh;
            FN_ADD, FN_ADDU: return a + b;
            FN_SUB, FN_SUBU: return a - b;
            FN_AND:          return a & b;
            FN_OR:           return a | b;
            FN_XOR:          return a ^ b;
            FN_NOR:          return ~(a | b);
            FN_SLT:          return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:         return 32'd0;
        endcase
    endfunction

    // reference model stepping one accepted instruction per call.
    task automatic model_step(input logic [31:0] instr, output mips_wb_t exp_wb,
                              output logic exp_unk);
        logic [31:0] a, b, sx, zx, addr, pc4, next_pc;
        logic [4:0]  rt;
        logic        redirect;
        int          idx;
        a        = m_regs[instr[25:21]];
        rt       = instr[20:16];
        b        = m_regs[rt];
        sx       = {{16{instr[15]}}, instr[15:0]};
        zx       = {16'h0000, instr[15:0]};
        addr     = a + sx;
        idx      = int'(addr >> 2) % `MIPS_DMEM_WORDS;
        pc4      = m_pc + 32'd4;
        next_pc  = pc4;
        redirect = 1'b0;
        exp_wb   = '0;
        exp_unk  = 1'b0;
        if (!m_squash)
        begin
            case (instr[31:26])
                OP_RTYPE:
                begin
                    exp_wb = make_wb(instr[15:11],
                                     rtype_result(instr[5:0], a, b, instr[10:6]));
                end
                OP_ADDI, OP_ADDIU: exp_wb = make_wb(rt, a + sx);
                OP_ANDI:           exp_wb = make_wb(rt, a & zx);
                OP_ORI:            exp_wb = make_wb(rt, a | zx);
                OP_XORI:           exp_wb = make_wb(rt, a ^ zx);
                OP_LUI:            exp_wb = make_wb(rt, {instr[15:0], 16'h0000});
                OP_LW:             exp_wb = make_wb(rt, m_mem[idx]);
                OP_SW:             m_mem[idx] = b;
                OP_BEQ, OP_BNE:
                begin
                    redirect = ((a == b) == (instr[31:26] == OP_BEQ));
                    if (redirect)
                        next_pc = pc4 + (sx << 2);
                end
                OP_J:
                begin
                    redirect = 1'b1;
                    next_pc  = {pc4[31:28], instr[25:0], 2'b00};
                end
                default: exp_unk = 1'b1;
            endcase
        end
        if (exp_wb.valid && (exp_wb.rd != 5'd0))
            m_regs[exp_wb.rd] = exp_wb.data;
        m_pc     = next_pc;
        m_squash = redirect;
    endtask

    task automatic check_wb(input mips_wb_t exp);
        if ((o_wb.valid !== exp.valid) ||
            (exp.valid && ((o_wb.rd !== exp.rd) || (o_wb.data !== exp.data))))
        begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: wb got %b r%0d %h, expected %b r%0d %h", $time,
                     o_wb.valid, o_wb.rd, o_wb.data, exp.valid, exp.rd, exp.data);
        end
    endtask

    task automatic check_pc(input logic [`MIPS_XLEN-1:0] exp);
        if (o_pc !== exp)
        begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: pc got %h, expected %h", $time, o_pc, exp);
        end
    endtask

    task automatic check_unknown(input logic exp);
        if (o_unknown_command !== exp)
        begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: unknown flag got %b, expected %b", $time,
                     o_unknown_command, exp);
        end
    endtask

    // drive one instruction for a single edge and compare against the model.
    task automatic run_instr(input logic [31:0] instr);
        mips_wb_t exp_wb;
        logic     exp_unk;
        model_step(instr, exp_wb, exp_unk);
        i_instr       = instr;
        i_instr_valid = 1'b1;
        @(posedge i_clk);
        #1;
        i_instr_valid = 1'b0;
        check_wb(exp_wb);
        check_unknown(exp_unk);
        check_pc(m_pc);
    endtask

    task automatic idle_cycle();
        @(posedge i_clk);
        #1;
        check_wb('0);
        check_unknown(1'b0);
        check_pc(m_pc);
    endtask

    task automatic load_reg(input logic [4:0] r, input logic [31:0] value);
        run_instr(i_format(OP_LUI, 5'd0, r, value[31:16]));
        run_instr(i_format(OP_ORI, r, r, value[15:0]));
    endtask

    task automatic reset_state();
        check_wb('0);
        check_unknown(1'b0);
        check_pc(`MIPS_RESET_PC);
    endtask

    task automatic rtype_ops();
        mips_funct_e fns [11];
        logic [31:0] rnd;
        fns = '{FN_SLL, FN_SRL, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR,
                FN_NOR, FN_SLT};
        load_reg(5'd1, $random(seed));
        load_reg(5'd2, $random(seed));
        for (int k = 0; k < 11; k++)
        begin
            rnd = $random(seed);
            run_instr(r_format(fns[k], 5'd1, 5'd2, 5'(10 + k), rnd[4:0]));
            run_instr(r_format(fns[k], 5'd2, 5'd1, 5'd3, rnd[9:5])); // swapped operands.
        end
        run_instr(r_format(FN_ADD, 5'd1, 5'd2, 5'd0, 5'd0)); // r0 keeps zero.
        run_instr(r_format(FN_OR, 5'd0, 5'd0, 5'd4, 5'd0));
    endtask

    task automatic immediate_ops();
        logic [31:0] rnd;
        logic [15:0] neg;
        logic [15:0] pos;
        rnd = $random(seed);
        neg = {1'b1, rnd[14:0]};
        pos = {1'b0, rnd[30:16]};
        run_instr(i_format(OP_ADDI, 5'd1, 5'd5, neg));
        run_instr(i_format(OP_ADDI, 5'd1, 5'd5, pos));
        run_instr(i_format(OP_ADDIU, 5'd2, 5'd6, neg));
        run_instr(i_format(OP_ANDI, 5'd1, 5'd7, neg));
        run_instr(i_format(OP_ORI, 5'd2, 5'd8, neg));
        run_instr(i_format(OP_XORI, 5'd1, 5'd9, neg));
        run_instr(i_format(OP_LUI, 5'd1, 5'd5, neg));
    endtask

    task automatic load_store();
        run_instr(i_format(OP_ORI, 5'd0, 5'd6, 16'h0040)); // base at word 16.
        run_instr(i_format(OP_SW, 5'd6, 5'd1, 16'h0000));
        run_instr(i_format(OP_SW, 5'd6, 5'd2, 16'h0004));
        run_instr(i_format(OP_LW, 5'd6, 5'd7, 16'h0000));
        run_instr(i_format(OP_LW, 5'd6, 5'd8, 16'h0004));
        run_instr(i_format(OP_SW, 5'd6, 5'd2, 16'h0000));
        run_instr(i_format(OP_LW, 5'd6, 5'd9, 16'h0000));
        run_instr(i_format(OP_LW, 5'd6, 5'd10, 16'hfffc)); // word 15 is still clear.
        run_instr(i_format(OP_SW, 5'd6, 5'd1, 16'h00c4)); // wraps to word 1.
        run_instr(i_format(OP_LW, 5'd0, 5'd11, 16'h0004));
    endtask

    task automatic branches_and_jump();
        run_instr(i_format(OP_ORI, 5'd0, 5'd13, 16'h0005));
        run_instr(i_format(OP_ORI, 5'd0, 5'd14, 16'h0007));
        run_instr(i_format(OP_BEQ, 5'd13, 5'd13, 16'h0003));
        run_instr(i_format(OP_ADDI, 5'd13, 5'd15, 16'h0001)); // squashed slot.
        run_instr(i_format(OP_ADDI, 5'd13, 5'd15, 16'h0002));
        run_instr(i_format(OP_BEQ, 5'd13, 5'd14, 16'h0003));
        run_instr(i_format(OP_ADDI, 5'd14, 5'd15, 16'h0003));
        run_instr(i_format(OP_BNE, 5'd13, 5'd14, 16'hfff8)); // backwards.
        run_instr(j_format(26'h000_0040)); // a squashed jump must not redirect.
        run_instr(i_format(OP_BNE, 5'd14, 5'd14, 16'h0010));
        run_instr(i_format(OP_ADDI, 5'd14, 5'd16, 16'h0004));
        run_instr(j_format(26'h123_4567));
        run_instr(i_format(OP_SW, 5'd0, 5'd14, 16'h0008)); // squashed store.
        run_instr(i_format(OP_LW, 5'd0, 5'd17, 16'h0008));
    endtask

    task automatic unknown_opcodes();
        run_instr(i_format(6'h10, 5'd1, 5'd2, 16'h0000)); // cop0.
        idle_cycle();
        run_instr(i_format(6'h3f, 5'd1, 5'd2, 16'h1234));
        run_instr(j_format(26'h000_0010));
        run_instr(i_format(6'h10, 5'd1, 5'd2, 16'h0000));
        idle_cycle();
    endtask

    initial
    begin
        seed          = SEED;
        errors        = 0;
        i_rst_n       = 1'b0;
        i_instr       = '0;
        i_instr_valid = 1'b0;
        m_pc          = `MIPS_RESET_PC;
        m_squash      = 1'b0;
        for (int i = 0; i < `MIPS_NREGS; i++)
        begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < `MIPS_DMEM_WORDS; i++)
        begin
            m_mem[i] = '0;
        end
        repeat (5) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        reset_state();
        rtype_ops();
        immediate_ops();
        load_store();
        branches_and_jump();
        unknown_opcodes();
        $display("tests finished with %0d errors", errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
design/mips_pkg.sv
design/mips_control.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_data_mem.sv
design/mips_core.sv
test/tb_mips_core.sv

//--- Makefile
TOP       ?= tb_mips_core
LOG       ?= sim.log
VERILATOR ?= verilator
# 32'h1991_b788 in decimal.
SEED      ?= 428980104
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: TOP LOG VERILATOR SEED OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -f list.f
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
